// File: source/i3c_tgt_pkg.sv
//*********************************************************************
// Shared definitions of the I3C private-transfer target
//   Bus byte, target address and bit index types
//   Bit-count constants of the 9-bit frame
//   Target FSM state encoding
//*********************************************************************
`default_nettype none

package i3c_tgt_pkg;

  // One byte on the bus, data or address plus R/W
  typedef logic [7:0] bus_byte_t;
  // 7-bit target address
  typedef logic [6:0] tgt_addr_t;
  // Position within the 9-bit frame, 0 to 8
  typedef logic [3:0] bit_idx_t;

  // ACK slot is the ninth bit
  localparam bit_idx_t AckBitIdx = 4'd8;
  // Last data bit before the ACK slot
  localparam bit_idx_t LastDataBitIdx = 4'd7;

  typedef enum logic [6:0] {
    Idle, AcquireStart, AddrRead,
    AddrAckWait, AddrAckSetup, AddrAckPulse, AddrAckHold,
    TransmitWait, TransmitSetup, TransmitPulse, TransmitHold, TransmitAck, TransmitAckPulse,
    AcquireByte, AcquireAckWait, AcquireAckSetup, AcquireAckPulse, AcquireAckHold,
    WaitForStop
  } tgt_state_e;

endpackage

`default_nettype wire

// File: source/i3c_bus_monitor.sv
//*********************************************************************
// Bus monitor for SCL and SDA
//   One-cycle delayed copies of both lines
//   SCL edge strobes, START and STOP detection
//*********************************************************************
`timescale 1ns/1ns
`default_nettype none

module i3c_bus_monitor (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic scl_i,
  input  logic sda_i,
  output logic scl_posedge_o,
  output logic scl_negedge_o,
  output logic start_det_o,
  output logic stop_det_o
);

  // Previous-cycle values of the bus lines
  logic scl_q;
  logic sda_q;

  // Idle bus is high on both lines
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_q <= 1'b1;
      sda_q <= 1'b1;
    end else begin
      scl_q <= scl_i;
      sda_q <= sda_i;
    end
  end

  // Edge strobes against the delayed copy
  assign scl_posedge_o = scl_i & ~scl_q;
  assign scl_negedge_o = ~scl_i & scl_q;

  // START is SDA falling with SCL high in both cycles
  assign start_det_o = scl_i & scl_q & sda_q & ~sda_i;
  // STOP is SDA rising with SCL high in both cycles
  assign stop_det_o = scl_i & scl_q & ~sda_q & sda_i;

endmodule

`default_nettype wire

// File: source/i3c_bit_engine.sv
//*********************************************************************
// Bit engine of the target
//   Bit counter over the 9-bit frame
//   Receive shift register, MSB first
//   Host ACK capture in the ACK slot
//*********************************************************************
`timescale 1ns/1ns
`default_nettype none

module i3c_bit_engine
  import i3c_tgt_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      sda_i,
  input  logic      scl_posedge_i,
  input  logic      scl_negedge_i,
  input  logic      start_det_i,
  input  logic      byte_clr_i,
  output bit_idx_t  bit_idx_o,
  output logic      bit_ack_o,
  output bus_byte_t input_byte_o,
  output logic      host_ack_o
);

  bit_idx_t  bit_idx_q;
  bus_byte_t shift_q;
  logic      host_ack_q;

  assign bit_ack_o = (bit_idx_q == AckBitIdx);

  // Advance on SCL falling edges, wrap after the ACK slot
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bit_idx_q <= '0;
    end else if (start_det_i || byte_clr_i) begin
      bit_idx_q <= '0;
    end else if (scl_negedge_i) begin
      if (bit_ack_o) begin
        bit_idx_q <= '0;
      end else begin
        bit_idx_q <= bit_idx_q + 4'd1;
      end
    end
  end

  // Data bits shift in on SCL rising edges, ACK slot excluded
  always_ff @(posedge clk_i) begin
    if (byte_clr_i) begin
      shift_q <= '0;
    end else if (scl_posedge_i && !bit_ack_o) begin
      shift_q <= {shift_q[6:0], sda_i};
    end
  end

  // Low SDA in the ACK slot means the host acknowledged
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      host_ack_q <= 1'b0;
    end else if (scl_posedge_i && bit_ack_o) begin
      host_ack_q <= ~sda_i;
    end
  end

  assign bit_idx_o    = bit_idx_q;
  assign input_byte_o = shift_q;
  assign host_ack_o   = host_ack_q;

endmodule

`default_nettype wire

// File: source/i3c_delay_timer.sv
//*********************************************************************
// Delay timer for SDA setup and hold
//   Loadable down-counter, setup sum or hold time
//   Done flag in the last counted cycle
//*********************************************************************
`timescale 1ns/1ns
`default_nettype none

module i3c_delay_timer #(
  parameter int TcountWidth = 13
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   enable_i,
  input  logic                   load_setup_i,
  input  logic                   load_hold_i,
  input  logic [TcountWidth-1:0] t_r_i,
  input  logic [TcountWidth-1:0] tsu_dat_i,
  input  logic [TcountWidth-1:0] thd_dat_i,
  output logic                   tcount_done_o
);

  // One extra bit holds the carry of the setup sum
  logic [TcountWidth:0] tcount_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tcount_q <= '1;
    end else if (load_setup_i) begin
      tcount_q <= {1'b0, t_r_i} + {1'b0, tsu_dat_i};
    end else if (load_hold_i) begin
      tcount_q <= {1'b0, thd_dat_i};
    end else if (enable_i) begin
      tcount_q <= tcount_q - 1'b1;
    end
  end

  assign tcount_done_o = (tcount_q == (TcountWidth + 1)'(1));

endmodule

`default_nettype wire

// File: source/i3c_target_fsm.sv
//*********************************************************************
// Transfer FSM of the private-transfer target
//   Address match, ACK drive and read data shifting
//   RX and TX FIFO strobes
//   Command complete, NACK and unexpected STOP events
//*********************************************************************
`timescale 1ns/1ns
`default_nettype none

module i3c_target_fsm
  import i3c_tgt_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      target_enable_i,
  input  tgt_addr_t target_address_i,
  input  logic      scl_i,
  input  logic      scl_negedge_i,
  input  logic      start_det_i,
  input  logic      stop_det_i,
  input  bit_idx_t  bit_idx_i,
  input  logic      bit_ack_i,
  input  bus_byte_t input_byte_i,
  input  logic      host_ack_i,
  input  logic      tcount_done_i,
  input  logic      rx_wready_i,
  input  logic      tx_rvalid_i,
  input  bus_byte_t tx_rdata_i,
  output logic      sda_o,
  output logic      target_idle_o,
  output logic      byte_clr_o,
  output logic      load_setup_o,
  output logic      load_hold_o,
  output logic      rx_wvalid_o,
  output bus_byte_t rx_wdata_o,
  output logic      tx_rready_o,
  output logic      bus_rnw_o,
  output logic      event_cmd_complete_o,
  output logic      event_target_nack_o,
  output logic      event_unexp_stop_o
);

  tgt_state_e state_q, state_d;
  // Transfer addressed this target
  logic       xfer_q, xfer_d;
  // R/W bit of the matched address
  logic       rnw_q, rnw_d;
  // Rest of the transaction is NACKed
  logic       nack_q, nack_d;
  logic       sda_q, sda_d;
  // Byte being sent, all ones when the TX FIFO was empty
  bus_byte_t  tx_byte_q;
  logic       tx_valid_q;
  logic       latch_tx;

  always_comb begin
    state_d      = state_q;
    xfer_d       = xfer_q;
    rnw_d        = rnw_q;
    nack_d       = nack_q;
    sda_d        = 1'b1;
    byte_clr_o   = 1'b0;
    load_setup_o = 1'b0;
    load_hold_o  = 1'b0;
    latch_tx     = 1'b0;
    rx_wvalid_o  = 1'b0;
    tx_rready_o  = 1'b0;
    unique case (state_q)
      Idle: begin
        xfer_d = 1'b0;
        nack_d = 1'b0;
      end
      // Wait for SCL low after START, restart the frame
      AcquireStart: begin
        xfer_d = 1'b0;
        if (!scl_i) begin
          byte_clr_o = 1'b1;
          state_d    = AddrRead;
        end
      end
      // Address and R/W complete once the ACK slot begins
      AddrRead: begin
        if (bit_ack_i) begin
          if (input_byte_i[7:1] == target_address_i) begin
            xfer_d      = 1'b1;
            rnw_d       = input_byte_i[0];
            load_hold_o = 1'b1;
            state_d     = AddrAckWait;
          end else begin
            state_d = WaitForStop;
          end
        end
      end
      // Hold time after SCL fell, then drive the ACK
      AddrAckWait: begin
        if (scl_i) begin
          // Controller too fast, give up on the transaction
          nack_d  = 1'b1;
          state_d = WaitForStop;
        end else if (tcount_done_i) begin
          load_setup_o = 1'b1;
          state_d      = AddrAckSetup;
        end
      end
      AddrAckSetup: begin
        sda_d = 1'b0;
        if (tcount_done_i) state_d = AddrAckPulse;
      end
      // ACK held low until the slot's SCL falling edge
      AddrAckPulse: begin
        sda_d = 1'b0;
        if (scl_negedge_i) begin
          load_hold_o = 1'b1;
          state_d     = AddrAckHold;
        end
      end
      AddrAckHold: begin
        sda_d = 1'b0;
        if (tcount_done_i) state_d = rnw_q ? TransmitWait : AcquireByte;
      end
      // Take the next TX byte, or send all ones
      TransmitWait: begin
        latch_tx     = 1'b1;
        load_setup_o = 1'b1;
        state_d      = TransmitSetup;
      end
      TransmitSetup: begin
        sda_d = tx_byte_q[3'(LastDataBitIdx - bit_idx_i)];
        if (tcount_done_i) state_d = TransmitPulse;
      end
      TransmitPulse: begin
        sda_d = sda_q;
        if (scl_negedge_i) begin
          load_hold_o = 1'b1;
          state_d     = TransmitHold;
        end
      end
      // Keep the bit for the hold time, then next bit or host ACK
      TransmitHold: begin
        sda_d = sda_q;
        if (tcount_done_i) begin
          if (bit_ack_i) begin
            state_d = TransmitAck;
          end else begin
            load_setup_o = 1'b1;
            state_d      = TransmitSetup;
          end
        end
      end
      // SDA released for the host ACK
      TransmitAck: begin
        if (scl_i) state_d = TransmitAckPulse;
      end
      TransmitAckPulse: begin
        if (scl_negedge_i) begin
          // Pop only a byte that really came from the FIFO
          tx_rready_o = tx_valid_q;
          state_d     = host_ack_i ? TransmitWait : WaitForStop;
        end
      end
      // A full byte arrived, check FIFO room before ACKing
      AcquireByte: begin
        if (bit_ack_i) begin
          nack_d      = nack_q | ~rx_wready_i;
          load_hold_o = 1'b1;
          state_d     = AcquireAckWait;
        end
      end
      AcquireAckWait: begin
        if (scl_i) begin
          nack_d  = 1'b1;
          state_d = WaitForStop;
        end else if (tcount_done_i) begin
          if (nack_q) begin
            state_d = WaitForStop;
          end else begin
            load_setup_o = 1'b1;
            state_d      = AcquireAckSetup;
          end
        end
      end
      AcquireAckSetup: begin
        sda_d = 1'b0;
        if (tcount_done_i) state_d = AcquireAckPulse;
      end
      AcquireAckPulse: begin
        sda_d = 1'b0;
        if (scl_negedge_i) begin
          load_hold_o = 1'b1;
          state_d     = AcquireAckHold;
        end
      end
      // Byte goes to the RX FIFO as SDA is released
      AcquireAckHold: begin
        sda_d = 1'b0;
        if (tcount_done_i) begin
          rx_wvalid_o = 1'b1;
          state_d     = AcquireByte;
        end
      end
      WaitForStop: begin
        sda_d = 1'b1;
      end
      default: begin
        state_d = Idle;
      end
    endcase

    // Bus conditions and disable take priority over the state sequence
    if (!target_enable_i) begin
      state_d = Idle;
    end else if (start_det_i) begin
      state_d = AcquireStart;
    end else if (stop_det_i) begin
      state_d = Idle;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= Idle;
      xfer_q     <= 1'b0;
      rnw_q      <= 1'b0;
      nack_q     <= 1'b0;
      sda_q      <= 1'b1;
      tx_valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      xfer_q  <= xfer_d;
      rnw_q   <= rnw_d;
      nack_q  <= nack_d;
      sda_q   <= sda_d;
      if (latch_tx) tx_valid_q <= tx_rvalid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (latch_tx) tx_byte_q <= tx_rvalid_i ? tx_rdata_i : 8'hFF;
  end

  assign sda_o         = sda_d;
  assign target_idle_o = (state_q == Idle);
  assign rx_wdata_o    = input_byte_i;
  assign bus_rnw_o     = rnw_q;

  // Transfer end for this target, on START or STOP
  assign event_cmd_complete_o = target_enable_i & xfer_q & (start_det_i | stop_det_i);
  // First NACK of a transaction only
  assign event_target_nack_o  = nack_d & ~nack_q;
  // STOP in a read before the host NACKed
  assign event_unexp_stop_o   = target_enable_i & xfer_q & rnw_q & stop_det_i &
                                (state_q != WaitForStop);

endmodule

`default_nettype wire

// File: source/i3c_target_top.sv
//*********************************************************************
// Top level of the I3C private-transfer target
//   Bus monitor, bit engine, delay timer and transfer FSM
//*********************************************************************
`timescale 1ns/1ns
`default_nettype none

module i3c_target_top
  import i3c_tgt_pkg::*;
#(
  parameter int TcountWidth = 13
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   target_enable_i,
  input  tgt_addr_t              target_address_i,
  input  logic                   scl_i,
  input  logic                   sda_i,
  input  logic [TcountWidth-1:0] t_r_i,
  input  logic [TcountWidth-1:0] tsu_dat_i,
  input  logic [TcountWidth-1:0] thd_dat_i,
  input  logic                   rx_wready_i,
  input  logic                   tx_rvalid_i,
  input  bus_byte_t              tx_rdata_i,
  output logic                   sda_o,
  output logic                   target_idle_o,
  output logic                   rx_wvalid_o,
  output bus_byte_t              rx_wdata_o,
  output logic                   tx_rready_o,
  output logic                   bus_rnw_o,
  output logic                   event_cmd_complete_o,
  output logic                   event_target_nack_o,
  output logic                   event_unexp_stop_o
);

  // Bus events
  logic      scl_posedge;
  logic      scl_negedge;
  logic      start_det;
  logic      stop_det;
  // Bit engine to FSM
  bit_idx_t  bit_idx;
  logic      bit_ack;
  bus_byte_t input_byte;
  logic      host_ack;
  logic      byte_clr;
  // Delay timer control
  logic      load_setup;
  logic      load_hold;
  logic      tcount_done;

  i3c_bus_monitor u_bus_monitor (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .scl_i         (scl_i),
    .sda_i         (sda_i),
    .scl_posedge_o (scl_posedge),
    .scl_negedge_o (scl_negedge),
    .start_det_o   (start_det),
    .stop_det_o    (stop_det)
  );

  i3c_bit_engine u_bit_engine (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .sda_i         (sda_i),
    .scl_posedge_i (scl_posedge),
    .scl_negedge_i (scl_negedge),
    .start_det_i   (start_det),
    .byte_clr_i    (byte_clr),
    .bit_idx_o     (bit_idx),
    .bit_ack_o     (bit_ack),
    .input_byte_o  (input_byte),
    .host_ack_o    (host_ack)
  );

  i3c_delay_timer #(
    .TcountWidth (TcountWidth)
  ) u_delay_timer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .enable_i      (target_enable_i),
    .load_setup_i  (load_setup),
    .load_hold_i   (load_hold),
    .t_r_i         (t_r_i),
    .tsu_dat_i     (tsu_dat_i),
    .thd_dat_i     (thd_dat_i),
    .tcount_done_o (tcount_done)
  );

  i3c_target_fsm u_target_fsm (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .target_enable_i      (target_enable_i),
    .target_address_i     (target_address_i),
    .scl_i                (scl_i),
    .scl_negedge_i        (scl_negedge),
    .start_det_i          (start_det),
    .stop_det_i           (stop_det),
    .bit_idx_i            (bit_idx),
    .bit_ack_i            (bit_ack),
    .input_byte_i         (input_byte),
    .host_ack_i           (host_ack),
    .tcount_done_i        (tcount_done),
    .rx_wready_i          (rx_wready_i),
    .tx_rvalid_i          (tx_rvalid_i),
    .tx_rdata_i           (tx_rdata_i),
    .sda_o                (sda_o),
    .target_idle_o        (target_idle_o),
    .byte_clr_o           (byte_clr),
    .load_setup_o         (load_setup),
    .load_hold_o          (load_hold),
    .rx_wvalid_o          (rx_wvalid_o),
    .rx_wdata_o           (rx_wdata_o),
    .tx_rready_o          (tx_rready_o),
    .bus_rnw_o            (bus_rnw_o),
    .event_cmd_complete_o (event_cmd_complete_o),
    .event_target_nack_o  (event_target_nack_o),
    .event_unexp_stop_o   (event_unexp_stop_o)
  );

endmodule

`default_nettype wire

// File: tb/tb_clk_gen.sv
//*********************************************************************
// Testbench clock source
//   Free-running clock with a configurable period
//*********************************************************************
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
  parameter int PeriodNs = 100
) (
  output logic clk_o
);

  initial clk_o = 1'b0;

  // Half period per toggle
  always #(PeriodNs / 2) clk_o = ~clk_o;

endmodule

`default_nettype wire

// File: tb/i3c_target_checker.sv
//*********************************************************************
// Protocol checker bound to the target top level
//   Single-cycle RX write and TX read strobes
//   No SDA drive while idle, no RX write without FIFO room
//*********************************************************************
`timescale 1ns/1ns
`default_nettype none

module i3c_target_checker (
  input logic clk_i,
  input logic rst_ni,
  input logic rx_wvalid_i,
  input logic rx_wready_i,
  input logic tx_rready_i,
  input logic sda_drive_i,
  input logic target_idle_i
);

  // Failed assertions, read by the testbench at the end of the run
  int unsigned fail_count = 0;

  // RX write strobe lasts one cycle
  rx_wvalid_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_wvalid_i |=> !rx_wvalid_i)
  else begin
    fail_count++;
    $error("rx_wvalid_o high for more than one cycle");
  end

  // TX pop strobe lasts one cycle
  tx_rready_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx_rready_i |=> !tx_rready_i)
  else begin
    fail_count++;
    $error("tx_rready_o high for more than one cycle");
  end

  // Idle target leaves SDA released
  idle_sda_released: assert property (@(posedge clk_i) disable iff (!rst_ni)
    target_idle_i |-> sda_drive_i)
  else begin
    fail_count++;
    $error("sda_o pulled low while target_idle_o is high");
  end

  // Writes only go to a FIFO with room
  rx_write_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_wvalid_i |-> rx_wready_i)
  else begin
    fail_count++;
    $error("rx_wvalid_o issued while rx_wready_i is low");
  end

endmodule

bind i3c_target_top i3c_target_checker u_checker (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .rx_wvalid_i   (rx_wvalid_o),
  .rx_wready_i   (rx_wready_i),
  .tx_rready_i   (tx_rready_o),
  .sda_drive_i   (sda_o),
  .target_idle_i (target_idle_o)
);

`default_nettype wire

// File: tb/i3c_target_tb.sv
//*********************************************************************
// Testbench of the I3C private-transfer target
//   Controller model driving SCL and SDA, open-drain bus resolution
//   FIFO and event monitor on the falling clock edge
//   Write, address mismatch, read, unexpected STOP, back-pressure
//   and empty TX FIFO tests, cycle-count timeout
//*********************************************************************
`timescale 1ns/1ns
`default_nettype none

module i3c_target_tb
  import i3c_tgt_pkg::*;
;

  localparam int        TcountWidth = 13;
  localparam tgt_addr_t OwnAddr     = 7'h2A;
  localparam tgt_addr_t OtherAddr   = 7'h35;
  // About 17 frames of 144 cycles plus gaps and a wide margin
  localparam int        TimeoutCycles = 20000;

  logic                   clk;
  logic                   rst_n;
  logic                   scl;
  logic                   host_sda;
  logic                   sda_bus;
  logic                   target_enable;
  tgt_addr_t              target_address;
  logic [TcountWidth-1:0] t_r;
  logic [TcountWidth-1:0] tsu_dat;
  logic [TcountWidth-1:0] thd_dat;
  logic                   rx_wready;
  logic                   tx_rvalid;
  bus_byte_t              tx_rdata;
  logic                   sda_drive;
  logic                   target_idle;
  logic                   rx_wvalid;
  bus_byte_t              rx_wdata;
  logic                   tx_rready;
  logic                   bus_rnw;
  logic                   ev_cmd_complete;
  logic                   ev_target_nack;
  logic                   ev_unexp_stop;

  // Scoreboard state
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          rx_count = 0;
  bus_byte_t   rx_log [32];
  int          tx_pops = 0;
  int          cmd_pulses = 0;
  int          nack_pulses = 0;
  int          unexp_pulses = 0;
  logic [31:0] rng_state = 32'hee6b03cd;
  bus_byte_t   wr_data [4];
  bus_byte_t   tx_data [3];

  tb_clk_gen #(.PeriodNs(100)) u_clk_gen (.clk_o(clk));

  // Open-drain bus where either side pulls low
  assign sda_bus = host_sda & sda_drive;

  i3c_target_top #(
    .TcountWidth (TcountWidth)
  ) UUT (
    .clk_i                (clk),
    .rst_ni               (rst_n),
    .target_enable_i      (target_enable),
    .target_address_i     (target_address),
    .scl_i                (scl),
    .sda_i                (sda_bus),
    .t_r_i                (t_r),
    .tsu_dat_i            (tsu_dat),
    .thd_dat_i            (thd_dat),
    .rx_wready_i          (rx_wready),
    .tx_rvalid_i          (tx_rvalid),
    .tx_rdata_i           (tx_rdata),
    .sda_o                (sda_drive),
    .target_idle_o        (target_idle),
    .rx_wvalid_o          (rx_wvalid),
    .rx_wdata_o           (rx_wdata),
    .tx_rready_o          (tx_rready),
    .bus_rnw_o            (bus_rnw),
    .event_cmd_complete_o (ev_cmd_complete),
    .event_target_nack_o  (ev_target_nack),
    .event_unexp_stop_o   (ev_unexp_stop)
  );

  function automatic logic [31:0] next_random(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAILED t=%0t %s got=%0h expected=%0h", $time, name, got, exp);
    end
  endtask

  // Strobes and events sampled mid-cycle where they are settled
  always @(negedge clk) begin
    if (rst_n) begin
      if (rx_wvalid) begin
        if (rx_count < 32) rx_log[rx_count] = rx_wdata;
        rx_count++;
      end
      if (tx_rready) tx_pops++;
      if (ev_cmd_complete) cmd_pulses++;
      if (ev_target_nack) nack_pulses++;
      if (ev_unexp_stop) unexp_pulses++;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TimeoutCycles) begin
      $display("Timeout after %0d cycles, test sequence did not finish", cycles);
      $display("Checks run: %0d, errors: %0d", checks, errors);
      $display("Something failed");
      $finish;
    end
  end

  // One bit slot entered right after SCL fell
  // SDA changes 2 cycles in with SCL low 8 and high 8 cycles
  task automatic drive_bit(input logic b, output logic seen);
    repeat (2) @(posedge clk);
    host_sda <= b;
    repeat (6) @(posedge clk);
    scl <= 1'b1;
    repeat (4) @(posedge clk);
    // Bus value in the middle of SCL high
    @(negedge clk);
    seen = sda_bus;
    repeat (4) @(posedge clk);
    scl <= 1'b0;
  endtask

  task automatic bus_start();
    @(posedge clk);
    host_sda <= 1'b0;
    repeat (4) @(posedge clk);
    scl <= 1'b0;
  endtask

  task automatic bus_stop();
    repeat (2) @(posedge clk);
    host_sda <= 1'b0;
    repeat (6) @(posedge clk);
    scl <= 1'b1;
    repeat (4) @(posedge clk);
    host_sda <= 1'b1;
    repeat (8) @(posedge clk);
  endtask

  // Eight data bits MSB first and then SDA released for the ACK slot
  task automatic send_byte(input bus_byte_t data, output logic sda_ack);
    logic seen;
    for (int i = 7; i >= 0; i--) begin
      drive_bit(data[i], seen);
    end
    drive_bit(1'b1, sda_ack);
  endtask

  // Host releases SDA for the data bits and then ACKs or NACKs
  task automatic recv_byte(input logic host_acks, input bus_byte_t next_tx,
                           output bus_byte_t got);
    logic seen;
    got = '0;
    for (int i = 0; i < 8; i++) begin
      drive_bit(1'b1, seen);
      got = {got[6:0], seen};
    end
    // Next FIFO head latched by the target after this ACK slot
    tx_rdata <= next_tx;
    drive_bit(~host_acks, seen);
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (!target_idle && n < 50) begin
      @(negedge clk);
      n++;
    end
    checks++;
    assert (target_idle) else begin
      errors++;
      $display("Target did not return to idle after STOP at t=%0t", $time);
    end
  endtask

  initial begin
    logic      ack;
    bus_byte_t got;
    int        rx_base;
    int        cmd_base;
    int        pop_base;
    int        unexp_base;
    int        nack_base;
    scl            = 1'b1;
    host_sda       = 1'b1;
    rst_n          = 1'b0;
    target_enable  = 1'b0;
    target_address = OwnAddr;
    t_r            = 13'd1;
    tsu_dat        = 13'd1;
    thd_dat        = 13'd1;
    rx_wready      = 1'b1;
    tx_rvalid      = 1'b0;
    tx_rdata       = 8'h00;
    tx_data[0]     = 8'h96;
    tx_data[1]     = 8'h5A;
    tx_data[2]     = 8'hC3;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    target_enable <= 1'b1;
    repeat (4) @(posedge clk);

    // Write of four random bytes to our address
    rx_base  = rx_count;
    cmd_base = cmd_pulses;
    bus_start();
    send_byte({OwnAddr, 1'b0}, ack);
    check_value("sda_i at address ACK", ack, 0);
    @(negedge clk);
    check_value("bus_rnw_o", bus_rnw, 0);
    check_value("target_idle_o", target_idle, 0);
    for (int i = 0; i < 4; i++) begin
      rng_state  = next_random(rng_state);
      wr_data[i] = rng_state[7:0];
      send_byte(wr_data[i], ack);
      check_value("sda_i at data ACK", ack, 0);
    end
    bus_stop();
    wait_idle();
    check_value("rx_wvalid_o count", rx_count - rx_base, 4);
    for (int i = 0; i < 4; i++) begin
      check_value("rx_wdata_o", rx_log[rx_base + i], wr_data[i]);
    end
    check_value("event_cmd_complete_o count", cmd_pulses - cmd_base, 1);

    // Write to another address is ignored
    rx_base  = rx_count;
    cmd_base = cmd_pulses;
    bus_start();
    send_byte({OtherAddr, 1'b0}, ack);
    check_value("sda_i at foreign address ACK", ack, 1);
    rng_state = next_random(rng_state);
    send_byte(rng_state[7:0], ack);
    check_value("sda_i at foreign data ACK", ack, 1);
    bus_stop();
    wait_idle();
    check_value("rx_wvalid_o count", rx_count - rx_base, 0);
    check_value("event_cmd_complete_o count", cmd_pulses - cmd_base, 0);

    // Read of three bytes with the last one NACKed by the host
    @(posedge clk);
    tx_rvalid  <= 1'b1;
    tx_rdata   <= tx_data[0];
    pop_base   = tx_pops;
    unexp_base = unexp_pulses;
    cmd_base   = cmd_pulses;
    bus_start();
    send_byte({OwnAddr, 1'b1}, ack);
    check_value("sda_i at address ACK", ack, 0);
    @(negedge clk);
    check_value("bus_rnw_o", bus_rnw, 1);
    for (int i = 0; i < 3; i++) begin
      recv_byte(i < 2, (i < 2) ? tx_data[i + 1] : 8'h00, got);
      check_value("sda_i read byte", got, tx_data[i]);
    end
    bus_stop();
    wait_idle();
    check_value("tx_rready_o count", tx_pops - pop_base, 3);
    check_value("event_unexp_stop_o count", unexp_pulses - unexp_base, 0);
    check_value("event_cmd_complete_o count", cmd_pulses - cmd_base, 1);

    // Read ended by STOP after an ACK
    // Second byte has its MSB set so SDA is free for the STOP
    @(posedge clk);
    tx_rdata   <= 8'h3C;
    pop_base   = tx_pops;
    unexp_base = unexp_pulses;
    bus_start();
    send_byte({OwnAddr, 1'b1}, ack);
    check_value("sda_i at address ACK", ack, 0);
    recv_byte(1'b1, 8'hC3, got);
    check_value("sda_i read byte", got, 8'h3C);
    bus_stop();
    wait_idle();
    check_value("event_unexp_stop_o count", unexp_pulses - unexp_base, 1);
    check_value("tx_rready_o count", tx_pops - pop_base, 1);

    // Write with a full RX FIFO
    @(posedge clk);
    rx_wready <= 1'b0;
    rx_base   = rx_count;
    nack_base = nack_pulses;
    bus_start();
    send_byte({OwnAddr, 1'b0}, ack);
    check_value("sda_i at address ACK", ack, 0);
    @(negedge clk);
    check_value("bus_rnw_o", bus_rnw, 0);
    rng_state = next_random(rng_state);
    send_byte(rng_state[7:0], ack);
    check_value("sda_i at data ACK", ack, 1);
    bus_stop();
    wait_idle();
    check_value("event_target_nack_o count", nack_pulses - nack_base, 1);
    check_value("rx_wvalid_o count", rx_count - rx_base, 0);

    // Read from an empty TX FIFO sends all ones
    @(posedge clk);
    rx_wready  <= 1'b1;
    tx_rvalid  <= 1'b0;
    tx_rdata   <= 8'h12;
    pop_base   = tx_pops;
    unexp_base = unexp_pulses;
    bus_start();
    send_byte({OwnAddr, 1'b1}, ack);
    check_value("sda_i at address ACK", ack, 0);
    recv_byte(1'b0, 8'h12, got);
    check_value("sda_i read byte", got, 8'hFF);
    bus_stop();
    wait_idle();
    check_value("tx_rready_o count", tx_pops - pop_base, 0);
    check_value("event_unexp_stop_o count", unexp_pulses - unexp_base, 0);

    check_value("checker assertion failures", UUT.u_checker.fail_count, 0);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
source/i3c_tgt_pkg.sv
source/i3c_bus_monitor.sv
source/i3c_bit_engine.sv
source/i3c_delay_timer.sv
source/i3c_target_fsm.sv
source/i3c_target_top.sv
tb/tb_clk_gen.sv
tb/i3c_target_checker.sv
tb/i3c_target_tb.sv

// File: Makefile
# Verilator build and run of the I3C target testbench

TOP := i3c_target_tb
SRCS := $(wildcard source/*.sv tb/*.sv)

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): list.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f list.f

# Pass only when the log holds the pass line
run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Everything OK$$" sim.log

clean:
	rm -rf obj_dir sim.log
